//--- source/gb_apu_pkg.sv
package gb_apu_pkg;

  // channel level, stereo output and frequency field
  typedef logic [3:0]  sample_t;
  typedef logic [7:0]  mix_t;
  typedef logic [10:0] freq_t;

  // timer reload base
  localparam freq_t FREQ_MAX = 11'd2047;

  // ----------------------------------------------------------
  // register offsets in the sound page
  localparam logic [7:0] ADDR_NR11 = 8'h11;
  localparam logic [7:0] ADDR_NR12 = 8'h12;
  localparam logic [7:0] ADDR_NR13 = 8'h13;
  localparam logic [7:0] ADDR_NR14 = 8'h14;
  localparam logic [7:0] ADDR_NR21 = 8'h16;
  localparam logic [7:0] ADDR_NR22 = 8'h17;
  localparam logic [7:0] ADDR_NR23 = 8'h18;
  localparam logic [7:0] ADDR_NR24 = 8'h19;
  localparam logic [7:0] ADDR_NR50 = 8'h24;
  localparam logic [7:0] ADDR_NR51 = 8'h25;
  localparam logic [7:0] ADDR_NR52 = 8'h26;

  // ----------------------------------------------------------
  // bits that always read back as one
  localparam logic [7:0] READ_MASK_NR11 = 8'h3F;
  localparam logic [7:0] READ_MASK_NR12 = 8'h00;
  localparam logic [7:0] READ_MASK_NR13 = 8'hFF;
  localparam logic [7:0] READ_MASK_NR14 = 8'hBF;
  localparam logic [7:0] READ_MASK_NR21 = 8'h3F;
  localparam logic [7:0] READ_MASK_NR22 = 8'h00;
  localparam logic [7:0] READ_MASK_NR23 = 8'hFF;
  localparam logic [7:0] READ_MASK_NR24 = 8'hBF;
  localparam logic [7:0] READ_MASK_NR50 = 8'h00;
  localparam logic [7:0] READ_MASK_NR51 = 8'h00;

  // bits set on every store
  localparam logic [7:0] WRITE_FORCE_NR11 = 8'h00;
  localparam logic [7:0] WRITE_FORCE_NR12 = 8'h00;
  localparam logic [7:0] WRITE_FORCE_NR13 = 8'h00;
  localparam logic [7:0] WRITE_FORCE_NR14 = 8'h38;
  localparam logic [7:0] WRITE_FORCE_NR21 = 8'h00;
  localparam logic [7:0] WRITE_FORCE_NR22 = 8'h00;
  localparam logic [7:0] WRITE_FORCE_NR23 = 8'h00;
  localparam logic [7:0] WRITE_FORCE_NR24 = 8'h38;
  localparam logic [7:0] WRITE_FORCE_NR50 = 8'h00;
  localparam logic [7:0] WRITE_FORCE_NR51 = 8'h00;
  localparam logic [7:0] WRITE_FORCE_NR52 = 8'h70;

  // ----------------------------------------------------------
  // power-on register contents
  localparam logic [7:0] RESET_NR11 = 8'hBF;
  localparam logic [7:0] RESET_NR12 = 8'hF3;
  localparam logic [7:0] RESET_NR13 = 8'hFF;
  localparam logic [7:0] RESET_NR14 = 8'hBF;
  localparam logic [7:0] RESET_NR21 = 8'h3F;
  localparam logic [7:0] RESET_NR22 = 8'h00;
  localparam logic [7:0] RESET_NR23 = 8'hFF;
  localparam logic [7:0] RESET_NR24 = 8'hBF;
  localparam logic [7:0] RESET_NR50 = 8'h77;
  localparam logic [7:0] RESET_NR51 = 8'hF3;
  localparam logic [7:0] RESET_NR52 = 8'hF1;

endpackage

//--- source/apu_regs.sv
`timescale 1ns/1ps

module apu_regs
  import gb_apu_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic [7:0] addr,
  input  logic [7:0] wdata,
  input  logic       read,
  input  logic       write,
  input  logic       active1,
  input  logic       active2,
  output logic [7:0] rdata,
  output logic       bus_oe,
  output logic       sound_on,
  output logic [7:0] pan,
  output logic [7:0] master_vol,
  output logic [1:0] duty1,
  output logic [5:0] length_load1,
  output logic [3:0] env_init1,
  output logic       env_dir1,
  output logic [2:0] env_period1,
  output freq_t      freq1,
  output logic       length_en1,
  output logic       trig1,
  output logic [1:0] duty2,
  output logic [5:0] length_load2,
  output logic [3:0] env_init2,
  output logic       env_dir2,
  output logic [2:0] env_period2,
  output freq_t      freq2,
  output logic       length_en2,
  output logic       trig2
);

  logic [7:0] nr11, nr12, nr13, nr14;
  logic [7:0] nr21, nr22, nr23, nr24;
  logic [7:0] nr50, nr51;
  logic       power;
  logic       power_off_wr;
  logic [7:0] rd_val;
  logic       rd_mapped;

  // NR52 accepts writes even while powered down
  assign power_off_wr = write && (addr == ADDR_NR52) && !wdata[7];

  // ----------------------------------------------------------
  // register storage
  always_ff @(posedge clk) begin
    if (rst || power_off_wr) begin
      nr11  <= RESET_NR11;
      nr12  <= RESET_NR12;
      nr13  <= RESET_NR13;
      nr14  <= RESET_NR14;
      nr21  <= RESET_NR21;
      nr22  <= RESET_NR22;
      nr23  <= RESET_NR23;
      nr24  <= RESET_NR24;
      nr50  <= RESET_NR50;
      nr51  <= RESET_NR51;
      power <= rst ? RESET_NR52[7] : 1'b0;
      trig1 <= 1'b0;
      trig2 <= 1'b0;
    end else begin
      trig1 <= 1'b0;
      trig2 <= 1'b0;
      if (write && addr == ADDR_NR52) begin
        power <= 1'b1;
      end else if (write && power) begin
        case (addr)
          ADDR_NR11: nr11 <= wdata | WRITE_FORCE_NR11;
          ADDR_NR12: nr12 <= wdata | WRITE_FORCE_NR12;
          ADDR_NR13: nr13 <= wdata | WRITE_FORCE_NR13;
          ADDR_NR14: begin
            nr14  <= wdata | WRITE_FORCE_NR14;
            trig1 <= wdata[7];
          end
          ADDR_NR21: nr21 <= wdata | WRITE_FORCE_NR21;
          ADDR_NR22: nr22 <= wdata | WRITE_FORCE_NR22;
          ADDR_NR23: nr23 <= wdata | WRITE_FORCE_NR23;
          ADDR_NR24: begin
            nr24  <= wdata | WRITE_FORCE_NR24;
            trig2 <= wdata[7];
          end
          ADDR_NR50: nr50 <= wdata | WRITE_FORCE_NR50;
          ADDR_NR51: nr51 <= wdata | WRITE_FORCE_NR51;
          default: ;
        endcase
      end
    end
  end

  // ----------------------------------------------------------
  // read decode
  always_comb begin
    rd_mapped = 1'b1;
    case (addr)
      ADDR_NR11: rd_val = nr11 | READ_MASK_NR11;
      ADDR_NR12: rd_val = nr12 | READ_MASK_NR12;
      ADDR_NR13: rd_val = nr13 | READ_MASK_NR13;
      ADDR_NR14: rd_val = nr14 | READ_MASK_NR14;
      ADDR_NR21: rd_val = nr21 | READ_MASK_NR21;
      ADDR_NR22: rd_val = nr22 | READ_MASK_NR22;
      ADDR_NR23: rd_val = nr23 | READ_MASK_NR23;
      ADDR_NR24: rd_val = nr24 | READ_MASK_NR24;
      ADDR_NR50: rd_val = nr50 | READ_MASK_NR50;
      ADDR_NR51: rd_val = nr51 | READ_MASK_NR51;
      // status: power, fixed ones, channel activity
      ADDR_NR52: rd_val = {power, 7'd0} | WRITE_FORCE_NR52 | {6'd0, active2, active1};
      default: begin
        rd_val    = 8'h00;
        rd_mapped = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      bus_oe <= 1'b0;
    end else if (read) begin
      bus_oe <= rd_mapped;
    end
  end

  always_ff @(posedge clk) begin
    if (read) begin
      rdata <= rd_val;
    end
  end

  // channel field extraction
  assign sound_on     = power;
  assign pan          = nr51;
  assign master_vol   = nr50;
  assign duty1        = nr11[7:6];
  assign length_load1 = nr11[5:0];
  assign env_init1    = nr12[7:4];
  assign env_dir1     = nr12[3];
  assign env_period1  = nr12[2:0];
  assign freq1        = {nr14[2:0], nr13};
  assign length_en1   = nr14[6];
  assign duty2        = nr21[7:6];
  assign length_load2 = nr21[5:0];
  assign env_init2    = nr22[7:4];
  assign env_dir2     = nr22[3];
  assign env_period2  = nr22[2:0];
  assign freq2        = {nr24[2:0], nr23};
  assign length_en2   = nr24[6];

  // bus master never strobes both at once
  a_no_rw_overlap : assert property (@(posedge clk) disable iff (rst) !(read && write));

endmodule

//--- source/frame_sequencer.sv
`timescale 1ns/1ps

module frame_sequencer #(
  parameter int STEP_DIV = 4,
  parameter int SEQ_BITS = 14
) (
  input  logic clk,
  input  logic rst,
  input  logic sound_on,
  output logic step,
  output logic length_tick,
  output logic env_tick
);

  localparam int DIV_W = (STEP_DIV > 1) ? $clog2(STEP_DIV) : 1;
  // envelope point at seven eighths of the counter range
  localparam logic [SEQ_BITS-1:0] ENV_POINT = SEQ_BITS'(7) << (SEQ_BITS - 3);

  logic [DIV_W-1:0]    div_cnt;
  logic [SEQ_BITS-1:0] seq_cnt;
  logic [SEQ_BITS-1:0] seq_next;
  logic                div_done;

  assign div_done = (div_cnt == DIV_W'(STEP_DIV - 1));
  assign seq_next = seq_cnt + 1'b1;

  always_ff @(posedge clk) begin
    if (rst) begin
      div_cnt     <= '0;
      seq_cnt     <= '0;
      step        <= 1'b0;
      length_tick <= 1'b0;
      env_tick    <= 1'b0;
    end else begin
      div_cnt     <= div_done ? '0 : div_cnt + 1'b1;
      step        <= div_done;
      length_tick <= 1'b0;
      env_tick    <= 1'b0;
      // sequencer parks at zero while powered down
      if (!sound_on) begin
        seq_cnt <= '0;
      end else if (div_done) begin
        seq_cnt     <= seq_next;
        length_tick <= (seq_next[SEQ_BITS-2:0] == '0);
        env_tick    <= (seq_next == ENV_POINT);
      end
    end
  end

  a_tick_on_step : assert property (@(posedge clk) disable iff (rst)
    (length_tick || env_tick) |-> step);

endmodule

//--- source/square_channel.sv
`timescale 1ns/1ps

module square_channel
  import gb_apu_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       sound_on,
  input  logic       step,
  input  logic       length_tick,
  input  logic       env_tick,
  input  logic       trigger,
  input  logic [1:0] duty,
  input  logic [5:0] length_load,
  input  logic       length_en,
  input  logic [3:0] env_init,
  input  logic       env_dir,
  input  logic [2:0] env_period,
  input  freq_t      freq,
  output sample_t    sample,
  output logic       active
);

  freq_t      timer;
  logic [2:0] phase;
  logic [6:0] len_cnt;
  sample_t    env_vol;
  logic [2:0] env_clk;
  logic [3:0] duty_thr;
  logic       dac_on;

  // high phases out of eight
  always_comb begin
    case (duty)
      2'd0:    duty_thr = 4'd1;
      2'd1:    duty_thr = 4'd2;
      2'd2:    duty_thr = 4'd4;
      default: duty_thr = 4'd6;
    endcase
  end

  assign dac_on = (env_init != 4'd0) || env_dir;

  always_ff @(posedge clk) begin
    if (rst || !sound_on) begin
      timer   <= '0;
      phase   <= '0;
      len_cnt <= '0;
      env_vol <= '0;
      env_clk <= '0;
      sample  <= '0;
      active  <= 1'b0;
    end else begin
      // ----------------------------------------------------------
      // frequency timer and waveform
      if (step) begin
        if (timer == '0) begin
          timer <= FREQ_MAX ^ freq;
          phase <= phase + 1'b1;
        end else begin
          timer <= timer - 1'b1;
        end
        sample <= (active && ({1'b0, phase} < duty_thr)) ? env_vol : '0;
      end

      // ----------------------------------------------------------
      // length counter
      if (length_tick && length_en && len_cnt != 7'd0) begin
        len_cnt <= len_cnt - 1'b1;
        if (len_cnt == 7'd1) begin
          active <= 1'b0;
          sample <= '0;
        end
      end

      // ----------------------------------------------------------
      // volume envelope, frozen at period zero
      if (env_tick && env_period != 3'd0) begin
        if (env_clk > 3'd1) begin
          env_clk <= env_clk - 1'b1;
        end else begin
          env_clk <= env_period;
          if (env_dir && env_vol != 4'd15) begin
            env_vol <= env_vol + 1'b1;
          end else if (!env_dir && env_vol != 4'd0) begin
            env_vol <= env_vol - 1'b1;
          end
        end
      end

      // restart takes priority over the counters above
      if (trigger) begin
        timer   <= FREQ_MAX ^ freq;
        phase   <= '0;
        len_cnt <= 7'd64 - {1'b0, length_load};
        env_vol <= env_init;
        env_clk <= env_period;
        active  <= dac_on;
        if (!dac_on) begin
          sample <= '0;
        end
      end
    end
  end

  // an idle voice contributes nothing to the mix
  a_silent_idle : assert property (@(posedge clk) disable iff (rst)
    !active |-> (sample == '0));

endmodule

//--- source/apu_mixer.sv
`timescale 1ns/1ps

module apu_mixer
  import gb_apu_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       sound_on,
  input  logic       step,
  input  sample_t    sample1,
  input  sample_t    sample2,
  input  logic [7:0] pan,
  input  logic [7:0] master_vol,
  output mix_t       out_l,
  output mix_t       out_r
);

  logic [4:0] sum_l;
  logic [4:0] sum_r;
  logic [3:0] vol_l;
  logic [3:0] vol_r;
  mix_t       mix_l;
  mix_t       mix_r;

  // panning, low nibble right and high nibble left
  assign sum_r = (pan[0] ? {1'b0, sample1} : 5'd0) + (pan[1] ? {1'b0, sample2} : 5'd0);
  assign sum_l = (pan[4] ? {1'b0, sample1} : 5'd0) + (pan[5] ? {1'b0, sample2} : 5'd0);

  // master volume field plus one, up to x8
  assign vol_r = {1'b0, master_vol[2:0]} + 4'd1;
  assign vol_l = {1'b0, master_vol[6:4]} + 4'd1;

  // 30 x 8 still fits in eight bits
  assign mix_r = sum_r * vol_r;
  assign mix_l = sum_l * vol_l;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_l <= '0;
      out_r <= '0;
    end else if (step) begin
      out_l <= sound_on ? mix_l : '0;
      out_r <= sound_on ? mix_r : '0;
    end
  end

endmodule

//--- source/gb_apu.sv
`timescale 1ns/1ps

module gb_apu
  import gb_apu_pkg::*;
#(
  parameter int STEP_DIV = 4,
  parameter int SEQ_BITS = 14
) (
  input  logic       clk,
  input  logic       rst,
  input  logic [7:0] addr,
  input  logic [7:0] wdata,
  input  logic       read,
  input  logic       write,
  output logic [7:0] rdata,
  output logic       bus_oe,
  output mix_t       out_l,
  output mix_t       out_r
);

  // ----------------------------------------------------------
  // register fields toward the voices and mixer
  logic       sound_on;
  logic [7:0] pan;
  logic [7:0] master_vol;
  logic [1:0] duty1, duty2;
  logic [5:0] length_load1, length_load2;
  logic [3:0] env_init1, env_init2;
  logic       env_dir1, env_dir2;
  logic [2:0] env_period1, env_period2;
  freq_t      freq1, freq2;
  logic       length_en1, length_en2;
  logic       trig1, trig2;

  // sequencer ticks and voice outputs
  logic       step;
  logic       length_tick;
  logic       env_tick;
  sample_t    sample1, sample2;
  logic       active1, active2;

  apu_regs regs0 (
    .clk, .rst, .addr, .wdata, .read, .write, .active1, .active2,
    .rdata, .bus_oe, .sound_on, .pan, .master_vol,
    .duty1, .length_load1, .env_init1, .env_dir1, .env_period1,
    .freq1, .length_en1, .trig1,
    .duty2, .length_load2, .env_init2, .env_dir2, .env_period2,
    .freq2, .length_en2, .trig2
  );

  frame_sequencer #(
    .STEP_DIV (STEP_DIV),
    .SEQ_BITS (SEQ_BITS)
  ) seq0 (
    .clk, .rst, .sound_on, .step, .length_tick, .env_tick
  );

  square_channel ch1 (
    .clk, .rst, .sound_on, .step, .length_tick, .env_tick,
    .trigger (trig1), .duty (duty1), .length_load (length_load1),
    .length_en (length_en1), .env_init (env_init1), .env_dir (env_dir1),
    .env_period (env_period1), .freq (freq1), .sample (sample1), .active (active1)
  );

  square_channel ch2 (
    .clk, .rst, .sound_on, .step, .length_tick, .env_tick,
    .trigger (trig2), .duty (duty2), .length_load (length_load2),
    .length_en (length_en2), .env_init (env_init2), .env_dir (env_dir2),
    .env_period (env_period2), .freq (freq2), .sample (sample2), .active (active2)
  );

  apu_mixer mix0 (
    .clk, .rst, .sound_on, .step, .sample1, .sample2, .pan, .master_vol,
    .out_l, .out_r
  );

endmodule

//--- verif/gb_apu_tb_ref.svh
`ifndef GB_APU_TB_REF_SVH
`define GB_APU_TB_REF_SVH

// ------------------------------------------------------------
// register readback
function automatic logic [7:0] read_mask(input logic [7:0] a);
  case (a)
    ADDR_NR11, ADDR_NR21: return 8'h3F;
    ADDR_NR13, ADDR_NR23: return 8'hFF;
    ADDR_NR14, ADDR_NR24: return 8'hBF;
    default:              return 8'h00;
  endcase
endfunction

function automatic logic [7:0] write_force(input logic [7:0] a);
  // frequency-high registers store bits 5..3 as ones
  if (a == ADDR_NR14 || a == ADDR_NR24) begin
    return 8'h38;
  end
  return 8'h00;
endfunction

function automatic logic [7:0] reset_value(input logic [7:0] a);
  case (a)
    ADDR_NR11: return 8'hBF;
    ADDR_NR12: return 8'hF3;
    ADDR_NR13: return 8'hFF;
    ADDR_NR14: return 8'hBF;
    ADDR_NR21: return 8'h3F;
    ADDR_NR22: return 8'h00;
    ADDR_NR23: return 8'hFF;
    ADDR_NR24: return 8'hBF;
    ADDR_NR50: return 8'h77;
    default:   return 8'hF3;
  endcase
endfunction

function automatic logic [7:0] readback_written(input logic [7:0] a, input logic [7:0] d);
  return d | write_force(a) | read_mask(a);
endfunction

function automatic logic [7:0] readback_reset(input logic [7:0] a);
  return reset_value(a) | read_mask(a);
endfunction

// power bit, fixed ones, channel activity
function automatic logic [7:0] status_byte(input logic power, input logic act1,
                                           input logic act2);
  return {power, 3'b111, 2'b00, act2, act1};
endfunction

// ------------------------------------------------------------
// mixer output levels
function automatic int mix_peak(input int l1, input int l2, input int scale);
  return (l1 + l2) * scale;
endfunction

// lowest nonzero level or zero when nothing is panned
function automatic int mix_floor(input int l1, input int l2, input int scale);
  if (l1 == 0) begin
    return l2 * scale;
  end
  if (l2 == 0 || l1 < l2) begin
    return l1 * scale;
  end
  return l2 * scale;
endfunction

function automatic logic mix_allowed(input int value, input int l1, input int l2,
                                     input int scale);
  return (value == 0) || (value == l1 * scale) || (value == l2 * scale) ||
         (value == (l1 + l2) * scale);
endfunction

`endif

//--- verif/gb_apu_tb.sv
`timescale 1ns/1ps

module gb_apu_tb
  import gb_apu_pkg::*;
();

  localparam int STEP_DIV     = 4;
  localparam int SEQ_BITS     = 8;
  localparam int CLK_PERIOD   = 4;
  localparam int DRIVE_DLY    = 1;
  localparam int RESET_CYCLES = 16;
  // clocks between two length ticks
  localparam int LEN_PERIOD   = (1 << (SEQ_BITS - 1)) * STEP_DIV;
  // reset/bus, random writes, status, length, mix, power-off
  localparam int TEST_PERIODS   = 1 + 1 + 1 + 7 + 2 + 1;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + (TEST_PERIODS + 4) * LEN_PERIOD;

  logic       clk = 1'b0;
  logic       rst;
  logic [7:0] addr;
  logic [7:0] wdata;
  logic       read;
  logic       write;
  logic [7:0] rdata;
  logic       bus_oe;
  mix_t       out_l;
  mix_t       out_r;

  // expected read results in strobe order
  logic [7:0] exp_addr_q[$];
  logic [7:0] exp_data_q[$];
  logic       exp_oe_q[$];
  logic       rd_pending = 1'b0;
  logic [7:0] exp_addr;
  logic [7:0] exp_data;
  logic       exp_oe;

  // mixer model
  logic mix_check_en;
  logic zero_check_en;
  int   l1_l, l2_l, scale_l;
  int   l1_r, l2_r, scale_r;
  logic seen_peak_l, seen_floor_l, seen_peak_r, seen_floor_r;

  int          checks;
  int          mismatches;
  int          failures;
  logic [31:0] rng;
  logic        exp_power, exp_act1, exp_act2;
  int          idx;
  int          round;
  int          len_l;
  logic [3:0]  v1, v2;
  logic [7:0]  pan_val, mvol_val, data;

  `include "gb_apu_tb_ref.svh"

  gb_apu #(
    .STEP_DIV (STEP_DIV),
    .SEQ_BITS (SEQ_BITS)
  ) dut0 (
    .clk, .rst, .addr, .wdata, .read, .write, .rdata, .bus_oe, .out_l, .out_r
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // kept registers with status last
  function automatic logic [7:0] kept_addr(input int i);
    case (i)
      0:       return ADDR_NR11;
      1:       return ADDR_NR12;
      2:       return ADDR_NR13;
      3:       return ADDR_NR14;
      4:       return ADDR_NR21;
      5:       return ADDR_NR22;
      6:       return ADDR_NR23;
      7:       return ADDR_NR24;
      8:       return ADDR_NR50;
      9:       return ADDR_NR51;
      default: return ADDR_NR52;
    endcase
  endfunction

  task automatic bus_write(input logic [7:0] a, input logic [7:0] d);
    @(posedge clk);
    #DRIVE_DLY;
    addr  = a;
    wdata = d;
    write = 1'b1;
    @(posedge clk);
    #DRIVE_DLY;
    write = 1'b0;
  endtask

  task automatic bus_read(input logic [7:0] a, input logic [7:0] d, input logic oe);
    exp_addr_q.push_back(a);
    exp_data_q.push_back(d);
    exp_oe_q.push_back(oe);
    @(posedge clk);
    #DRIVE_DLY;
    addr = a;
    read = 1'b1;
    @(posedge clk);
    #DRIVE_DLY;
    read = 1'b0;
  endtask

  task automatic check_mix(input string name, input int value, input int l1, input int l2,
                           input int scale, inout logic seen_peak, inout logic seen_floor);
    checks++;
    assert (mix_allowed(value, l1, l2, scale)) else begin
      mismatches++;
      $display("CHECK FAILED t=%0t %s expected one of {0, %0d, %0d, %0d} actual %0d",
               $time, name, l1 * scale, l2 * scale, mix_peak(l1, l2, scale), value);
    end
    if (value != 0 && value == mix_peak(l1, l2, scale)) begin
      seen_peak = 1'b1;
    end
    if (value != 0 && value == mix_floor(l1, l2, scale)) begin
      seen_floor = 1'b1;
    end
  endtask

  task automatic check_seen(input string name, input logic seen_peak, input logic seen_floor,
                            input int l1, input int l2, input int scale);
    if (mix_peak(l1, l2, scale) != 0) begin
      checks += 2;
      assert (seen_peak) else begin
        failures++;
        $display("%s never showed its peak level %0d within one length period",
                 name, mix_peak(l1, l2, scale));
      end
      assert (seen_floor) else begin
        failures++;
        $display("%s never showed its lowest nonzero level %0d within one length period",
                 name, mix_floor(l1, l2, scale));
      end
    end
  endtask

  task automatic print_counts;
    $display("checks: %0d, mismatches: %0d, other failures: %0d",
             checks, mismatches, failures);
  endtask

  // ------------------------------------------------------------
  // compare process sampling mid-cycle
  always @(posedge clk) begin
    rd_pending <= read;
  end

  always @(negedge clk) begin
    if (rd_pending) begin
      if (exp_oe_q.size() == 0) begin
        failures++;
        $display("t=%0t a read finished with no expected result waiting", $time);
      end else begin
        exp_addr = exp_addr_q.pop_front();
        exp_data = exp_data_q.pop_front();
        exp_oe   = exp_oe_q.pop_front();
        checks++;
        assert (bus_oe == exp_oe) else begin
          mismatches++;
          $display("CHECK FAILED t=%0t bus_oe at %02h expected %0b actual %0b",
                   $time, exp_addr, exp_oe, bus_oe);
        end
        if (exp_oe) begin
          checks++;
          assert (rdata == exp_data) else begin
            mismatches++;
            $display("CHECK FAILED t=%0t rdata at %02h expected %02h actual %02h",
                     $time, exp_addr, exp_data, rdata);
          end
        end
      end
    end
    if (mix_check_en) begin
      check_mix("out_l", out_l, l1_l, l2_l, scale_l, seen_peak_l, seen_floor_l);
      check_mix("out_r", out_r, l1_r, l2_r, scale_r, seen_peak_r, seen_floor_r);
    end
    if (zero_check_en) begin
      checks += 2;
      assert (out_l == '0) else begin
        mismatches++;
        $display("CHECK FAILED t=%0t out_l expected 0 actual %0d", $time, out_l);
      end
      assert (out_r == '0) else begin
        mismatches++;
        $display("CHECK FAILED t=%0t out_r expected 0 actual %0d", $time, out_r);
      end
    end
  end

  // ------------------------------------------------------------
  // watchdog
  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    failures++;
    $display("watchdog expired after %0d cycles, test sequence did not finish",
             TIMEOUT_CYCLES);
    print_counts();
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    rst           = 1'b1;
    addr          = 8'h00;
    wdata         = 8'h00;
    read          = 1'b0;
    write         = 1'b0;
    mix_check_en  = 1'b0;
    zero_check_en = 1'b0;
    checks        = 0;
    mismatches    = 0;
    failures      = 0;
    rng           = 32'd84537;
    exp_power     = 1'b1;
    exp_act1      = 1'b0;
    exp_act2      = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DLY;
    rst = 1'b0;

    // reset contents, then offsets of dropped channels
    for (idx = 0; idx < 10; idx++) begin
      bus_read(kept_addr(idx), readback_reset(kept_addr(idx)), 1'b1);
    end
    bus_read(ADDR_NR52, status_byte(exp_power, exp_act1, exp_act2), 1'b1);
    bus_read(8'h10, 8'h00, 1'b0);
    bus_read(8'h1A, 8'h00, 1'b0);
    bus_read(8'h15, 8'h00, 1'b0);

    // random data through every writable register
    for (round = 0; round < 2; round++) begin
      for (idx = 0; idx < 10; idx++) begin
        rng  = xorshift32(rng);
        data = rng[7:0];
        bus_write(kept_addr(idx), data);
        bus_read(kept_addr(idx), readback_written(kept_addr(idx), data), 1'b1);
      end
    end

    // power cycle clears the voices
    bus_write(ADDR_NR52, 8'h00);
    bus_write(ADDR_NR52, 8'h80);
    bus_read(ADDR_NR52, status_byte(exp_power, exp_act1, exp_act2), 1'b1);

    // ------------------------------------------------------------
    // trigger and status bits
    // full initial volume starts channel 1
    bus_write(ADDR_NR12, 8'hF0);
    bus_write(ADDR_NR14, 8'h80);
    exp_act1 = 1'b1;
    // silent and falling envelope leaves channel 2 off
    bus_write(ADDR_NR22, 8'h00);
    bus_write(ADDR_NR24, 8'h80);
    exp_act2 = 1'b0;
    bus_read(ADDR_NR52, status_byte(exp_power, exp_act1, exp_act2), 1'b1);
    // zero volume with rising envelope keeps the DAC on
    bus_write(ADDR_NR22, 8'h08);
    bus_write(ADDR_NR24, 8'h80);
    exp_act2 = 1'b1;
    bus_read(ADDR_NR52, status_byte(exp_power, exp_act1, exp_act2), 1'b1);

    // length counter on channel 1
    rng   = xorshift32(rng);
    len_l = 58 + (rng % 5);
    bus_write(ADDR_NR11, 8'h80 | len_l[7:0]);
    bus_write(ADDR_NR14, 8'hC0);
    exp_act1 = 1'b1;
    repeat ((63 - len_l) * LEN_PERIOD - 16) @(posedge clk);
    bus_read(ADDR_NR52, status_byte(exp_power, exp_act1, exp_act2), 1'b1);
    repeat (2 * LEN_PERIOD + 32) @(posedge clk);
    exp_act1 = 1'b0;
    bus_read(ADDR_NR52, status_byte(exp_power, exp_act1, exp_act2), 1'b1);

    // ------------------------------------------------------------
    // mix levels with frozen envelopes
    rng      = xorshift32(rng);
    v1       = rng[3:0] % 15 + 1;
    v2       = rng[11:8] % 15 + 1;
    // channel 1 always reaches both sides
    pan_val  = rng[23:16] | 8'h11;
    rng      = xorshift32(rng);
    mvol_val = rng[7:0];
    bus_write(ADDR_NR50, mvol_val);
    bus_write(ADDR_NR51, pan_val);
    bus_write(ADDR_NR11, 8'h80);
    bus_write(ADDR_NR12, {v1, 4'h8});
    bus_write(ADDR_NR13, 8'hFF);
    bus_write(ADDR_NR14, 8'h87);
    // half the rate of channel 1 so every high/low pairing shows up
    bus_write(ADDR_NR21, 8'h80);
    bus_write(ADDR_NR22, {v2, 4'h8});
    bus_write(ADDR_NR23, 8'hFE);
    bus_write(ADDR_NR24, 8'h87);
    l1_l         = pan_val[4] ? v1 : 0;
    l2_l         = pan_val[5] ? v2 : 0;
    scale_l      = mvol_val[6:4] + 1;
    l1_r         = pan_val[0] ? v1 : 0;
    l2_r         = pan_val[1] ? v2 : 0;
    scale_r      = mvol_val[2:0] + 1;
    seen_peak_l  = 1'b0;
    seen_floor_l = 1'b0;
    seen_peak_r  = 1'b0;
    seen_floor_r = 1'b0;
    repeat (4 * STEP_DIV) @(posedge clk);
    mix_check_en = 1'b1;
    repeat (LEN_PERIOD) @(posedge clk);
    mix_check_en = 1'b0;
    check_seen("out_l", seen_peak_l, seen_floor_l, l1_l, l2_l, scale_l);
    check_seen("out_r", seen_peak_r, seen_floor_r, l1_r, l2_r, scale_r);

    // ------------------------------------------------------------
    // power off
    bus_write(ADDR_NR52, 8'h00);
    exp_power = 1'b0;
    exp_act1  = 1'b0;
    exp_act2  = 1'b0;
    repeat (STEP_DIV + 1) @(posedge clk);
    zero_check_en = 1'b1;
    // ignored while powered down
    bus_write(ADDR_NR50, 8'h00);
    bus_read(ADDR_NR52, status_byte(exp_power, exp_act1, exp_act2), 1'b1);
    for (idx = 0; idx < 10; idx++) begin
      bus_read(kept_addr(idx), readback_reset(kept_addr(idx)), 1'b1);
    end
    repeat (2) @(posedge clk);
    zero_check_en = 1'b0;

    print_counts();
    if (mismatches == 0 && failures == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- gb_apu.f
+incdir+verif
source/gb_apu_pkg.sv
source/apu_regs.sv
source/frame_sequencer.sv
source/square_channel.sv
source/apu_mixer.sv
source/gb_apu.sv
verif/gb_apu_tb.sv
